// File: logic/audio_pkg.sv
// audio word width, bit counter type and stereo sample struct
package audio_pkg;

   // ========================================
   // word format
   // ========================================
   localparam int SAMPLE_BITS     = 24;   // bits per audio word
   localparam int SAMPLE_CNT_BITS = 5;

   typedef logic [SAMPLE_BITS-1:0]     sample_t;
   typedef logic [SAMPLE_CNT_BITS-1:0] bit_idx_t;

   // counter value of the last bit in a word
   localparam bit_idx_t LAST_BIT = bit_idx_t'(SAMPLE_BITS - 1);

   // ========================================
   // stereo pair
   // ========================================
   typedef struct packed {
      sample_t left;    // upper half
      sample_t right;
   } stereo_t;

endpackage

// File: logic/codec_cfg_pkg.sv
// control-bus timing, device address, register write type, register table, sequencer states
package codec_cfg_pkg;

   // ========================================
   // control-bus timing
   // ========================================
   localparam int TICK_DIV    = 4;     // aud_bclk cycles per half bit
   localparam int FRAME_GAP   = 16;    // idle ticks after stop
   localparam int FRAME_BITS  = 27;    // three bytes, three ack slots
   localparam int FRAME_TICKS = 2 + FRAME_BITS * 2 + 2 + FRAME_GAP;

   localparam int BIT_POS_FIRST = 2;   // after the start ticks
   localparam int BIT_POS_LAST  = BIT_POS_FIRST + FRAME_BITS * 2 - 1;
   localparam int STOP_POS      = BIT_POS_LAST + 1;

   typedef logic [$clog2(TICK_DIV)-1:0]    tick_div_t;
   typedef logic [$clog2(FRAME_TICKS)-1:0] tick_pos_t;

   // ========================================
   // register writes
   // ========================================
   typedef logic [7:0] cfg_byte_t;
   typedef logic [3:0] cfg_idx_t;

   localparam cfg_byte_t DEV_ADDR_W = 8'h34;   // address 0x1a, write
   localparam int        REG_COUNT  = 10;

   typedef struct packed {
      cfg_byte_t sub_addr;   // register number times two
      cfg_byte_t data;
   } reg_write_t;

   localparam reg_write_t CFG_TABLE [REG_COUNT] = '{
      '{8'h00, 8'h4b},   // left line in
      '{8'h02, 8'h4b},
      '{8'h04, 8'h79},   // headphone out
      '{8'h06, 8'h79},
      '{8'h08, 8'h08},
      '{8'h0a, 8'h06},
      '{8'h0c, 8'h00},
      '{8'h0e, 8'h4a},   // i2s, 24 bit, master
      '{8'h10, 8'h00},
      '{8'h12, 8'h01}    // activate
   };

   typedef enum logic [1:0] {
      CFG_IDLE,
      CFG_ISSUE,
      CFG_WAIT
   } cfg_state_t;

endpackage

// File: logic/i2s_rx.sv
// I2S receiver capturing left and right 24-bit words from the ADC line
`timescale 1ns/1ps

module i2s_rx (
   input  logic               aud_bclk,
   input  logic               rstn,
   input  logic               aud_adclrc,
   input  logic               aud_adcdat,
   output audio_pkg::stereo_t rx_sample,
   output logic               rx_left_valid,
   output logic               rx_right_valid
);
   import audio_pkg::*;

   logic       lrc_q;
   logic [1:0] word_start;     // 0 left, 1 right
   logic [1:0] active_q;
   logic [1:0] valid_q;
   bit_idx_t   cnt_q   [2];
   sample_t    shift_q [2];
   sample_t    hold_q  [2];

   assign word_start[0] = lrc_q && !aud_adclrc;
   assign word_start[1] = !lrc_q && aud_adclrc;

   // ========================================
   // capture windows
   // ========================================
   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
      begin
         lrc_q    <= 1'b0;
         active_q <= '0;
         valid_q  <= '0;
         cnt_q    <= '{default: '0};
         hold_q   <= '{default: '0};
      end
      else
      begin
         lrc_q <= aud_adclrc;
         for (int ch = 0; ch < 2; ch++)
         begin
            valid_q[ch] <= active_q[ch] && (cnt_q[ch] == LAST_BIT);
            if (word_start[ch])
            begin
               active_q[ch] <= 1'b1;
               cnt_q[ch]    <= '0;
            end
            else if (active_q[ch])
            begin
               if (cnt_q[ch] == LAST_BIT)
                  active_q[ch] <= 1'b0;
               else
                  cnt_q[ch] <= cnt_q[ch] + 1'b1;
            end
            if (valid_q[ch])
               hold_q[ch] <= shift_q[ch];   // held until next word
         end
      end
   end

   // msb arrives first
   always_ff @(posedge aud_bclk)
   begin
      for (int ch = 0; ch < 2; ch++)
      begin
         if (active_q[ch])
            shift_q[ch] <= {shift_q[ch][SAMPLE_BITS-2:0], aud_adcdat};
      end
   end

   assign rx_sample      = '{left: hold_q[0], right: hold_q[1]};
   assign rx_left_valid  = valid_q[0];
   assign rx_right_valid = valid_q[1];

endmodule

// File: logic/i2s_tx.sv
// I2S transmitter shifting held left and right words onto the DAC line
`timescale 1ns/1ps

module i2s_tx (
   input  logic               aud_bclk,
   input  logic               rstn,
   input  logic               aud_daclrc,
   input  audio_pkg::stereo_t rx_sample,
   output logic               aud_dacdat
);
   import audio_pkg::*;

   logic       lrc_q;
   logic [1:0] word_start;     // 0 left, 1 right
   logic [1:0] active_q;
   bit_idx_t   cnt_q    [2];
   sample_t    src_word [2];
   sample_t    word_q   [2];

   assign word_start[0] = lrc_q && !aud_daclrc;
   assign word_start[1] = !lrc_q && aud_daclrc;
   assign src_word[0]   = rx_sample.left;
   assign src_word[1]   = rx_sample.right;

   // ========================================
   // word windows on rising edges
   // ========================================
   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
      begin
         lrc_q    <= 1'b0;
         active_q <= '0;
         cnt_q    <= '{default: '0};
      end
      else
      begin
         lrc_q <= aud_daclrc;
         for (int ch = 0; ch < 2; ch++)
         begin
            if (word_start[ch])
            begin
               active_q[ch] <= 1'b1;
               cnt_q[ch]    <= '0;
            end
            else if (active_q[ch])
            begin
               if (cnt_q[ch] == LAST_BIT)
                  active_q[ch] <= 1'b0;
               else
                  cnt_q[ch] <= cnt_q[ch] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge aud_bclk)
   begin
      for (int ch = 0; ch < 2; ch++)
      begin
         if (word_start[ch])
            word_q[ch] <= src_word[ch];   // repeats if rx held
      end
   end

   // ========================================
   // serial output on falling edges
   // ========================================
   always_ff @(negedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
         aud_dacdat <= 1'b0;
      else if (active_q[0])
         aud_dacdat <= word_q[0][LAST_BIT - cnt_q[0]];
      else if (active_q[1])
         aud_dacdat <= word_q[1][LAST_BIT - cnt_q[1]];
   end

endmodule

// File: logic/cfg_sequencer.sv
// codec configuration sequencer stepping through the register table
`timescale 1ns/1ps

module cfg_sequencer (
   input  logic                      aud_bclk,
   input  logic                      rstn,
   input  logic                      aud_en,
   input  logic                      write_done,
   output logic                      write_start,
   output codec_cfg_pkg::reg_write_t write_word,
   output logic                      cfg_done
);
   import codec_cfg_pkg::*;

   logic [2:0] en_q;      // two sync flops, then previous value
   logic       en_rise;
   cfg_state_t state_q;
   cfg_idx_t   idx_q;

   assign en_rise = en_q[1] && !en_q[2];

   // ========================================
   // table walk
   // ========================================
   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
      begin
         en_q     <= '0;
         state_q  <= CFG_IDLE;
         idx_q    <= '0;
         cfg_done <= 1'b0;
      end
      else
      begin
         en_q <= {en_q[1:0], aud_en};
         case (state_q)
            CFG_IDLE:
            begin
               if (en_rise)
               begin
                  idx_q    <= '0;
                  cfg_done <= 1'b0;
                  state_q  <= CFG_ISSUE;
               end
            end
            CFG_ISSUE:
               state_q <= CFG_WAIT;       // one strobe per entry
            CFG_WAIT:
            begin
               if (write_done)
               begin
                  if (idx_q == cfg_idx_t'(REG_COUNT - 1))
                  begin
                     state_q  <= CFG_IDLE;
                     cfg_done <= 1'b1;
                  end
                  else
                  begin
                     idx_q   <= idx_q + 1'b1;
                     state_q <= CFG_ISSUE;
                  end
               end
            end
            default:
               state_q <= CFG_IDLE;
         endcase
      end
   end

   assign write_start = (state_q == CFG_ISSUE);
   assign write_word  = CFG_TABLE[idx_q];   // stable until next write_done

endmodule

// File: logic/ctrl_bus_writer.sv
// two-wire control-bus write engine with start, three bytes, ack slots, stop and gap
`timescale 1ns/1ps

module ctrl_bus_writer (
   input  logic                      aud_bclk,
   input  logic                      rstn,
   input  logic                      write_start,
   input  codec_cfg_pkg::reg_write_t write_word,
   output logic                      write_done,
   output logic                      ctrl_scl,
   output logic                      ctrl_sda
);
   import codec_cfg_pkg::*;

   logic                  busy_q;
   tick_div_t             div_q;
   tick_pos_t             pos_q;      // half-bit position in frame
   logic [FRAME_BITS-1:0] shift_q;
   logic                  tick;
   logic                  last_pos;
   logic                  in_bits;
   logic                  scl_next;
   logic                  sda_next;

   assign tick     = busy_q && (div_q == tick_div_t'(TICK_DIV - 1));
   assign last_pos = (pos_q == tick_pos_t'(FRAME_TICKS - 1));
   assign in_bits  = (pos_q >= BIT_POS_FIRST) && (pos_q <= BIT_POS_LAST);

   // ========================================
   // tick and position counters
   // ========================================
   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
      begin
         busy_q     <= 1'b0;
         div_q      <= '0;
         pos_q      <= '0;
         write_done <= 1'b0;
      end
      else
      begin
         write_done <= tick && last_pos;   // after gap
         if (!busy_q)
         begin
            if (write_start)
            begin
               busy_q <= 1'b1;
               div_q  <= '0;
               pos_q  <= '0;
            end
         end
         else if (tick)
         begin
            div_q <= '0;
            if (last_pos)
               busy_q <= 1'b0;
            else
               pos_q <= pos_q + 1'b1;
         end
         else
         begin
            div_q <= div_q + 1'b1;
         end
      end
   end

   // ack slots carry a one, data line stays driven
   always_ff @(posedge aud_bclk)
   begin
      if (write_start && !busy_q)
         shift_q <= {DEV_ADDR_W, 1'b1, write_word.sub_addr, 1'b1, write_word.data, 1'b1};
      else if (tick && in_bits && pos_q[0])
         shift_q <= {shift_q[FRAME_BITS-2:0], 1'b1};
   end

   // ========================================
   // line levels per position
   // ========================================
   always_comb
   begin
      scl_next = 1'b1;
      sda_next = 1'b1;
      if (pos_q < BIT_POS_FIRST)
      begin
         scl_next = !pos_q[0];            // start
         sda_next = 1'b0;
      end
      else if (in_bits)
      begin
         scl_next = pos_q[0];             // low half first
         sda_next = shift_q[FRAME_BITS-1];
      end
      else if (pos_q <= STOP_POS + 1)
      begin
         scl_next = pos_q[0];             // low, then high before stop
         sda_next = 1'b0;
      end
   end

   // data moves one cycle after the clock edge
   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
      begin
         ctrl_scl <= 1'b1;
         ctrl_sda <= 1'b1;
      end
      else if (busy_q)
      begin
         if (div_q == tick_div_t'(0))
            ctrl_scl <= scl_next;
         if (div_q == tick_div_t'(1))
            ctrl_sda <= sda_next;
      end
   end

endmodule

// File: logic/audio_loop_top.sv
// top level of the codec loopback controller, configuration and I2S loopback paths
`timescale 1ns/1ps

module audio_loop_top (
   input  logic aud_bclk,
   input  logic rstn,
   input  logic aud_en,
   input  logic aud_adclrc,
   input  logic aud_adcdat,
   input  logic aud_daclrc,
   output logic aud_dacdat,
   output logic ctrl_scl,
   output logic ctrl_sda,
   output logic cfg_done
);
   import audio_pkg::*;
   import codec_cfg_pkg::*;

   logic       write_start;
   reg_write_t write_word;
   logic       write_done;
   stereo_t    rx_sample;

   // ========================================
   // configuration path
   // ========================================
   cfg_sequencer seq_i (
      .aud_bclk    (aud_bclk),
      .rstn        (rstn),
      .aud_en      (aud_en),
      .write_done  (write_done),
      .write_start (write_start),
      .write_word  (write_word),
      .cfg_done    (cfg_done)
   );

   ctrl_bus_writer bus_i (
      .aud_bclk    (aud_bclk),
      .rstn        (rstn),
      .write_start (write_start),
      .write_word  (write_word),
      .write_done  (write_done),
      .ctrl_scl    (ctrl_scl),
      .ctrl_sda    (ctrl_sda)
   );

   // ========================================
   // loopback path
   // ========================================
   i2s_rx rx_i (
      .aud_bclk       (aud_bclk),
      .rstn           (rstn),
      .aud_adclrc     (aud_adclrc),
      .aud_adcdat     (aud_adcdat),
      .rx_sample      (rx_sample),
      .rx_left_valid  (),
      .rx_right_valid ()
   );

   i2s_tx tx_i (
      .aud_bclk   (aud_bclk),
      .rstn       (rstn),
      .aud_daclrc (aud_daclrc),
      .rx_sample  (rx_sample),
      .aud_dacdat (aud_dacdat)
   );

endmodule

// File: tb/tb_codec_models.svh
// control-bus frame decoder, I2S source and DAC sink tasks for the loopback testbench
`ifndef TB_CODEC_MODELS_SVH
`define TB_CODEC_MODELS_SVH

typedef struct packed {
   logic [3:0] byte_cnt;
   logic       acks_high;
   cfg_byte_t  dev;
   cfg_byte_t  sub_addr;
   cfg_byte_t  data;
} ctrl_frame_t;

// ========================================
// control-bus decoder
// ========================================
task automatic decode_ctrl_frame(output ctrl_frame_t frame);
   logic       scl_prev;
   logic       sda_prev;
   logic [8:0] group;
   int         bit_cnt;
   bit         started;
   bit         stopped;
   frame           = '0;
   frame.acks_high = 1'b1;
   group           = '0;
   bit_cnt         = 0;
   started         = 0;
   stopped         = 0;
   scl_prev        = ctrl_scl;
   sda_prev        = ctrl_sda;
   while (!stopped)
   begin
      @(posedge aud_bclk);
      if (scl_prev && ctrl_scl && sda_prev && !ctrl_sda)
         started = 1;                                  // start condition
      else if (started && scl_prev && ctrl_scl && !sda_prev && ctrl_sda)
         stopped = 1;
      else if (started && !scl_prev && ctrl_scl)
      begin
         group   = {group[7:0], ctrl_sda};
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 9)
         begin
            // eight data bits then the ack slot
            {frame.dev, frame.sub_addr, frame.data} = {frame.sub_addr, frame.data, group[8:1]};
            frame.acks_high = frame.acks_high & group[0];
            frame.byte_cnt  = frame.byte_cnt + 1'b1;
            bit_cnt         = 0;
         end
      end
      scl_prev = ctrl_scl;
      sda_prev = ctrl_sda;
   end
endtask

// ========================================
// I2S source and sink
// ========================================
task automatic drive_i2s_frame(input stereo_t word, input bit adc_on);
   logic data_bit;
   for (int t = 0; t < 64; t++)
   begin
      @(posedge aud_bclk);
      data_bit = 1'b0;
      if (adc_on && t >= 1 && t <= 24)
         data_bit = word.left[24 - t];           // one bit after the lrc edge
      else if (adc_on && t >= 33 && t <= 56)
         data_bit = word.right[56 - t];
      #5;
      aud_daclrc = (t >= 32);
      aud_adclrc = adc_on ? (t >= 32) : 1'b1;    // parked high when idle
      aud_adcdat = data_bit;
   end
endtask

task automatic capture_dac_frame(output stereo_t word);
   word = '0;
   for (int t = 0; t < 64; t++)
   begin
      @(posedge aud_bclk);
      if (t >= 2 && t <= 25)
         word.left = {word.left[SAMPLE_BITS-2:0], aud_dacdat};
      else if (t >= 34 && t <= 57)
         word.right = {word.right[SAMPLE_BITS-2:0], aud_dacdat};
   end
endtask

`endif

// File: tb/tb_audio_loop.sv
// testbench for the codec loopback controller with clock, reset, stimulus, checks and timeout
`timescale 1ns/1ps

module tb_audio_loop;
   import audio_pkg::*;
   import codec_cfg_pkg::*;

   localparam int CFG_FRAME_TICKS = 74;
   localparam int CFG_RUN_CYCLES  = REG_COUNT * CFG_FRAME_TICKS * TICK_DIV + 64;
   localparam int HOLD_CYCLES     = 2 * CFG_FRAME_TICKS * TICK_DIV;
   localparam int TIMEOUT_CYCLES  = 2 * (2 * REG_COUNT * CFG_FRAME_TICKS * TICK_DIV + 40 * 64);
   localparam cfg_byte_t EXP_DATA [10] = '{8'h4b, 8'h4b, 8'h79, 8'h79, 8'h08,
                                          8'h06, 8'h00, 8'h4a, 8'h00, 8'h01};

   logic aud_bclk = 1'b0;
   logic rstn;
   logic aud_en;
   logic aud_adclrc;
   logic aud_adcdat;
   logic aud_daclrc;
   logic aud_dacdat;
   logic ctrl_scl;
   logic ctrl_sda;
   logic cfg_done;

   `include "tb_codec_models.svh"

   int          seed;
   int          cycle_cnt = 0;
   int          test_errors = 0;
   int          total_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   ctrl_frame_t frames_q [$];
   sample_t     left_model [$];
   sample_t     right_model [$];

   audio_loop_top dut_i (.*);

   always #50 aud_bclk = ~aud_bclk;

   always @(posedge aud_bclk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run stopped after %0d cycles", cycle_cnt);
         $display(">>> FAIL");
         $finish;
      end
   end

   // every decoded control-bus frame lands here
   initial
   begin
      ctrl_frame_t frame;
      wait (rstn === 1'b1);
      forever
      begin
         decode_ctrl_frame(frame);
         frames_q.push_back(frame);
      end
   end

   // ========================================
   // checks and test bookkeeping
   // ========================================
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic expect_true(input bit cond, input string what);
      assert (cond)
      else
      begin
         $display("%s", what);
         test_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "passed" : "failed",
               test_errors);
      tests_run++;
      if (test_errors != 0)
         tests_failed++;
      total_errors += test_errors;
      test_errors = 0;
   endtask

   task automatic check_config_run(input string name);
      ctrl_frame_t frame;
      int          waited;
      @(posedge aud_bclk);
      #5 aud_en = 1'b1;
      for (waited = 0; waited < 8 && cfg_done; waited++)
         @(posedge aud_bclk);
      expect_true(!cfg_done, {name, ": cfg_done did not fall after the enable edge"});
      for (waited = 0; waited < CFG_RUN_CYCLES && !cfg_done; waited++)
         @(posedge aud_bclk);
      expect_true(cfg_done, {name, ": cfg_done never rose"});
      expect_true(frames_q.size() == REG_COUNT,
                  $sformatf("%s: decoded %0d frames instead of ten", name, frames_q.size()));
      for (int i = 0; i < REG_COUNT && frames_q.size() > 0; i++)
      begin
         frame = frames_q.pop_front();
         expect_true(frame.byte_cnt == 3 && frame.acks_high,
                     $sformatf("%s: frame %0d has bad byte count or ack level", name, i));
         check_value($sformatf("%s frame %0d dev", name, i), 8'h34, frame.dev);
         check_value($sformatf("%s frame %0d sub", name, i), 2 * i, frame.sub_addr);
         check_value($sformatf("%s frame %0d data", name, i), EXP_DATA[i], frame.data);
      end
   endtask

   // expected DAC word is the last word the model saw captured
   task automatic run_audio_frame(input bit adc_on, input string name);
      stereo_t sent;
      stereo_t got;
      stereo_t exp_word;
      sent.left      = sample_t'($random(seed));
      sent.right     = sample_t'($random(seed));
      exp_word.left  = left_model[$];
      exp_word.right = right_model[$];
      fork
         drive_i2s_frame(sent, adc_on);
         capture_dac_frame(got);
      join
      check_value({name, " left"}, exp_word.left, got.left);
      check_value({name, " right"}, exp_word.right, got.right);
      if (adc_on)
      begin
         left_model.push_back(sent.left);
         right_model.push_back(sent.right);
      end
   endtask

   // ========================================
   // test sequence
   // ========================================
   initial
   begin
      seed       = 13092;
      rstn       = 1'b0;
      aud_en     = 1'b0;
      aud_adclrc = 1'b1;
      aud_daclrc = 1'b1;
      aud_adcdat = 1'b0;
      left_model.push_back('0);     // held words after reset
      right_model.push_back('0);
      repeat (2) @(posedge aud_bclk);
      #5 rstn = 1'b1;
      @(posedge aud_bclk);
      check_value("reset ctrl_scl", 1, ctrl_scl);
      check_value("reset ctrl_sda", 1, ctrl_sda);
      check_value("reset aud_dacdat", 0, aud_dacdat);
      check_value("reset cfg_done", 0, cfg_done);
      finish_test("reset_state");
      check_config_run("config_content");
      finish_test("config_content");
      repeat (HOLD_CYCLES) @(posedge aud_bclk);
      expect_true(frames_q.size() == 0, "enable_edge: frames appeared while aud_en stayed high");
      @(posedge aud_bclk);
      #5 aud_en = 1'b0;
      repeat (4) @(posedge aud_bclk);
      check_config_run("enable_edge");
      finish_test("enable_edge");
      for (int i = 0; i < 30; i++)
         run_audio_frame(1'b1, $sformatf("loopback frame %0d", i));
      finish_test("loopback");
      for (int i = 0; i < 4; i++)
         run_audio_frame(1'b0, $sformatf("missing frame %0d", i));
      for (int i = 0; i < 2; i++)
         run_audio_frame(1'b1, $sformatf("resumed frame %0d", i));
      finish_test("repeat_on_missing");
      $display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
               total_errors);
      if (total_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: sim.f
+incdir+tb
logic/audio_pkg.sv
logic/codec_cfg_pkg.sv
logic/i2s_rx.sv
logic/i2s_tx.sv
logic/cfg_sequencer.sv
logic/ctrl_bus_writer.sv
logic/audio_loop_top.sv
tb/tb_audio_loop.sv
